// File: all.f
+incdir+bench
logic/mul_pkg.sv
logic/mul_if.sv
logic/wallace_reduce.sv
logic/cla_adder.sv
logic/axil_mul_regs.sv
logic/mul_axil_top.sv
bench/mul_tb.sv

// File: Bender.yml
package:
  name: mul_axil

sources:
  - logic/mul_pkg.sv
  - logic/mul_if.sv
  - logic/wallace_reduce.sv
  - logic/cla_adder.sv
  - logic/axil_mul_regs.sv
  - logic/mul_axil_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/mul_tb.sv

// File: bench/mul_tb_tasks.svh
`ifndef MUL_TB_TASKS_SVH
`define MUL_TB_TASKS_SVH

// ----------------------------------------
// random bits

// x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? (state >> 1) ^ LFSR_TAPS : state >> 1;
endfunction

// one LFSR step per bit
function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;

    bits = '0;
    for (int i = 0; i < n; i++) begin
        bits       = {bits[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
endfunction

function automatic operand_t random_operand();
    return operand_t'(take_bits(OPERAND_W));
endfunction

// ----------------------------------------
// model

function automatic product_t expected_product(input operand_t a, input operand_t b);
    return product_t'(a) * product_t'(b);
endfunction

function automatic axil_resp_t expected_write_resp(input logic [AXIL_ADDR_W-1:0] addr);
    return (addr == REG_OPERANDS) ? OKAY : SLVERR;
endfunction

function automatic axil_resp_t expected_read_resp(input logic [AXIL_ADDR_W-1:0] addr);
    return (addr == REG_OPERANDS || addr == REG_RESULT) ? OKAY : SLVERR;
endfunction

function automatic logic [AXIL_ADDR_W-1:0] pick_unmapped();
    logic [AXIL_ADDR_W-1:0] addr;

    do begin
        addr = AXIL_ADDR_W'(take_bits(AXIL_ADDR_W));
    end while (addr == REG_OPERANDS || addr == REG_RESULT);
    return addr;
endfunction

// ----------------------------------------
// compare

task automatic check_product(input string what, input product_t got, input product_t exp);
    test_checks++;
    if (got !== exp) begin
        $display("error at %t: %s got %h, expected %h", $time, what, got, exp);
        test_errors++;
    end
endtask

task automatic check_operands(input string what, input operand_t got_a, input operand_t got_b,
                              input operand_t exp_a, input operand_t exp_b);
    test_checks++;
    if (got_a !== exp_a || got_b !== exp_b) begin
        $display("error at %t: %s got a=%h b=%h, expected a=%h b=%h",
                 $time, what, got_a, got_b, exp_a, exp_b);
        test_errors++;
    end
endtask

task automatic check_resp(input string what, input axil_resp_t got, input axil_resp_t exp);
    test_checks++;
    if (got !== exp) begin
        $display("error at %t: %s got %b, expected %s", $time, what, got, exp.name());
        test_errors++;
    end
endtask

task automatic check_word(input string what, input logic [AXIL_DATA_W-1:0] got,
                          input logic [AXIL_DATA_W-1:0] exp);
    test_checks++;
    if (got !== exp) begin
        $display("error at %t: %s got %h, expected %h", $time, what, got, exp);
        test_errors++;
    end
endtask

task automatic report_failure(input string msg);
    test_errors++;
    $display("failure at %t: %s", $time, msg);
endtask

// ----------------------------------------
// AXI4-Lite master tasks are entered and left just after a rising edge

task automatic axil_write(input logic [AXIL_ADDR_W-1:0] addr, input logic [AXIL_DATA_W-1:0] data,
                          input int hold, output axil_resp_t resp);
    axil_resp_t first_resp;

    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (!awready) begin
        @(posedge clk);
        #DRIVE_DLY;
    end
    if (!wready) begin
        report_failure("wready did not rise together with awready");
    end
    // handshake on this edge
    @(posedge clk);
    #DRIVE_DLY;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!bvalid) begin
        report_failure("bvalid did not rise after the write was accepted");
    end
    first_resp = axil_resp_t'(bresp);
    repeat (hold) begin
        @(posedge clk);
        #DRIVE_DLY;
        if (!bvalid) begin
            report_failure("bvalid dropped before bready");
        end
        check_resp("bresp", axil_resp_t'(bresp), first_resp);
    end
    bready = 1'b1;
    resp   = axil_resp_t'(bresp);
    @(posedge clk);
    #DRIVE_DLY;
    bready = 1'b0;
endtask

task automatic axil_read(input logic [AXIL_ADDR_W-1:0] addr, input int hold,
                         output logic [AXIL_DATA_W-1:0] data, output axil_resp_t resp);
    logic [AXIL_DATA_W-1:0] first_data;
    axil_resp_t             first_resp;

    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) begin
        @(posedge clk);
        #DRIVE_DLY;
    end
    @(posedge clk);
    #DRIVE_DLY;
    arvalid = 1'b0;
    if (!rvalid) begin
        report_failure("rvalid did not rise after the read was accepted");
    end
    first_data = rdata;
    first_resp = axil_resp_t'(rresp);
    repeat (hold) begin
        @(posedge clk);
        #DRIVE_DLY;
        if (!rvalid) begin
            report_failure("rvalid dropped before rready");
        end
        check_word("rdata", rdata, first_data);
        check_resp("rresp", axil_resp_t'(rresp), first_resp);
    end
    rready = 1'b1;
    data   = rdata;
    resp   = axil_resp_t'(rresp);
    @(posedge clk);
    #DRIVE_DLY;
    rready = 1'b0;
endtask

`endif

// File: bench/mul_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mul_tb;
    import mul_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int DRIVE_DLY  = 2;
    localparam logic [31:0] LFSR_SEED = 32'h080a_86af;

    localparam int N_RANDOM    = 300;
    localparam int N_CORNER    = 9;
    localparam int N_READBACK  = 20;
    localparam int N_ADDR      = 20;
    localparam int N_BURST     = 10;
    localparam int N_BP        = 20;
    localparam int MAX_POLLS   = 4;

    // worst-case bus transactions per item
    localparam int TX_COUNT = (N_RANDOM + N_CORNER) * (1 + MAX_POLLS) + N_READBACK * 2
                            + N_ADDR * 4 + N_BURST * (5 + MAX_POLLS) + N_BP * (2 + MAX_POLLS);
    localparam int CYCLE_LIMIT = TX_COUNT * 20 + 200;

    logic                     clk;
    logic                     rst;
    logic [AXIL_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [AXIL_DATA_W-1:0]   wdata;
    logic [AXIL_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [AXIL_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [AXIL_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;

    logic [31:0] lfsr_state;
    int          test_checks;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    int          cycles;

    // last written operands and their product
    operand_t model_a;
    operand_t model_b;
    product_t model_product;

    mul_axil_top UUT (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    `include "mul_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ----------------------------------------
    // operations on the register map

    task automatic write_operands(input operand_t a, input operand_t b, input int hold);
        axil_resp_t resp;

        axil_write(REG_OPERANDS, {16'h0, b, a}, hold, resp);
        check_resp("bresp", resp, expected_write_resp(REG_OPERANDS));
        model_a       = a;
        model_b       = b;
        model_product = expected_product(a, b);
    endtask

    task automatic poll_result(input int hold);
        logic [AXIL_DATA_W-1:0] data;
        axil_resp_t             resp;
        int                     polls;

        polls = 0;
        data  = '0;
        while (!data[RES_READY_BIT] && polls < MAX_POLLS) begin
            axil_read(REG_RESULT, hold, data, resp);
            check_resp("rresp", resp, expected_read_resp(REG_RESULT));
            polls++;
        end
        if (!data[RES_READY_BIT]) begin
            report_failure("ready bit still low after the last poll");
        end else begin
            check_product("product", data[PRODUCT_W-1:0], model_product);
        end
    endtask

    task automatic read_operands(input int hold);
        logic [AXIL_DATA_W-1:0] data;
        axil_resp_t             resp;

        axil_read(REG_OPERANDS, hold, data, resp);
        check_resp("rresp", resp, expected_read_resp(REG_OPERANDS));
        check_operands("operands", data[OP_A_LSB +: OPERAND_W], data[OP_B_LSB +: OPERAND_W],
                       model_a, model_b);
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %-16s %0d checks, %0d errors", name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // ----------------------------------------
    // tests

    task automatic random_multiplies();
        operand_t corners [3];

        corners = '{8'd0, 8'd1, 8'd255};
        foreach (corners[i]) begin
            foreach (corners[j]) begin
                write_operands(corners[i], corners[j], 0);
                poll_result(0);
            end
        end
        for (int n = 0; n < N_RANDOM; n++) begin
            write_operands(random_operand(), random_operand(), 0);
            poll_result(0);
        end
        report_test("random_mul");
    endtask

    task automatic operand_readback();
        for (int n = 0; n < N_READBACK; n++) begin
            write_operands(random_operand(), random_operand(), 0);
            read_operands(0);
        end
        report_test("readback");
    endtask

    task automatic unmapped_access();
        logic [AXIL_ADDR_W-1:0] addr;
        logic [AXIL_DATA_W-1:0] data;
        axil_resp_t             resp;

        for (int n = 0; n < N_ADDR; n++) begin
            addr = pick_unmapped();
            axil_read(addr, 0, data, resp);
            check_resp("rresp", resp, expected_read_resp(addr));
            check_word("rdata", data, '0);

            addr = take_bits(1) ? REG_RESULT : pick_unmapped();
            axil_write(addr, take_bits(32), 0, resp);
            check_resp("bresp", resp, expected_write_resp(addr));
            read_operands(0);
            axil_read(REG_RESULT, 0, data, resp);
            check_resp("rresp", resp, OKAY);
            check_product("product", data[PRODUCT_W-1:0], model_product);
            if (!data[RES_READY_BIT]) begin
                report_failure("ready bit cleared by a rejected write");
            end
        end
        report_test("unmapped");
    endtask

    task automatic back_to_back();
        int count;

        for (int n = 0; n < N_BURST; n++) begin
            count = 3 + take_bits(2) % 3;
            repeat (count) begin
                write_operands(random_operand(), random_operand(), 0);
            end
            poll_result(0);
        end
        report_test("back_to_back");
    endtask

    task automatic back_pressure();
        for (int n = 0; n < N_BP; n++) begin
            write_operands(random_operand(), random_operand(), take_bits(3));
            poll_result(take_bits(3));
            read_operands(take_bits(3));
        end
        report_test("back_pressure");
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 10);
        lfsr_state    = LFSR_SEED;
        test_checks   = 0;
        test_errors   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        cycles        = 0;
        model_a       = '0;
        model_b       = '0;
        model_product = '0;

        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '1;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;

        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;

        random_multiplies();
        operand_readback();
        unmapped_access();
        back_to_back();
        back_pressure();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/mul_axil_top.sv
`timescale 1ns/10ps
`default_nettype none

module mul_axil_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [mul_pkg::AXIL_ADDR_W-1:0]   awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [mul_pkg::AXIL_DATA_W-1:0]   wdata,
    input  logic [mul_pkg::AXIL_DATA_W/8-1:0] wstrb,
    input  logic                              wvalid,
    output logic                              wready,
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  logic                              bready,
    input  logic [mul_pkg::AXIL_ADDR_W-1:0]   araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [mul_pkg::AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  logic                              rready
);
    import mul_pkg::*;

    mul_if mul_bus ();

    // register slave, issues operands and collects the product
    axil_mul_regs #(
        .RESP_ON_UNMAPPED (SLVERR)
    ) u_regs (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .mul     (mul_bus.issuer)
    );

    // pipeline stage 1
    wallace_reduce u_reduce (
        .clk (clk),
        .rst (rst),
        .mul (mul_bus.reducer)
    );

    // pipeline stage 2
    cla_adder #(
        .WIDTH (PRODUCT_W)
    ) u_adder (
        .clk (clk),
        .rst (rst),
        .mul (mul_bus.adder)
    );

endmodule

`default_nettype wire

// File: logic/axil_mul_regs.sv
`timescale 1ns/10ps
`default_nettype none

module axil_mul_regs #(
    parameter mul_pkg::axil_resp_t RESP_ON_UNMAPPED = mul_pkg::SLVERR
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [mul_pkg::AXIL_ADDR_W-1:0]   awaddr,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [mul_pkg::AXIL_DATA_W-1:0]   wdata,
    input  logic [mul_pkg::AXIL_DATA_W/8-1:0] wstrb,
    input  logic                              wvalid,
    output logic                              wready,
    output logic [1:0]                        bresp,
    output logic                              bvalid,
    input  logic                              bready,
    input  logic [mul_pkg::AXIL_ADDR_W-1:0]   araddr,
    input  logic                              arvalid,
    output logic                              arready,
    output logic [mul_pkg::AXIL_DATA_W-1:0]   rdata,
    output logic [1:0]                        rresp,
    output logic                              rvalid,
    input  logic                              rready,
    mul_if.issuer                             mul
);
    import mul_pkg::*;

    localparam int CNT_W = $clog2(PIPE_DEPTH + 2);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(PIPE_DEPTH + 1);

    logic wr_take;
    logic wr_hs;
    logic op_write;
    logic rd_hs;

    logic [CNT_W-1:0] in_flight;
    logic             res_ready;
    product_t         res_product;

    logic [AXIL_DATA_W-1:0] rd_word;
    axil_resp_t             rd_resp;

    // ----------------------------------------
    // write channel
    assign wr_take  = awvalid && wvalid && !bvalid && !awready;
    assign wr_hs    = awready && awvalid && wvalid;
    assign op_write = wr_hs && (awaddr == REG_OPERANDS);

    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= wr_take;
            wready  <= wr_take;
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // operand register feeds the tree directly
    always_ff @(posedge clk) begin
        if (rst) begin
            mul.start <= 1'b0;
            mul.a     <= '0;
            mul.b     <= '0;
        end else begin
            mul.start <= op_write;
            if (op_write) begin
                mul.a <= wdata[OP_A_LSB +: OPERAND_W];
                mul.b <= wdata[OP_B_LSB +: OPERAND_W];
            end
        end
    end

    // ----------------------------------------
    // result register and multiplies in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight   <= '0;
            res_ready   <= 1'b0;
            res_product <= '0;
        end else begin
            if (op_write && !mul.done) begin
                in_flight <= in_flight + 1'b1;
            end else if (mul.done && !op_write) begin
                in_flight <= in_flight - 1'b1;
            end

            // ready only once the newest operands are through
            if (op_write) begin
                res_ready <= 1'b0;
            end else if (mul.done && in_flight == CNT_W'(1)) begin
                res_ready <= 1'b1;
            end

            if (mul.done) begin
                res_product <= mul.product;
            end
        end
    end

    // ----------------------------------------
    // read channel
    assign rd_hs = arready && arvalid;

    always_comb begin
        rd_word = '0;
        rd_resp = OKAY;
        case (araddr)
            REG_OPERANDS: begin
                rd_word[OP_A_LSB +: OPERAND_W] = mul.a;
                rd_word[OP_B_LSB +: OPERAND_W] = mul.b;
            end
            REG_RESULT: begin
                rd_word[PRODUCT_W-1:0]  = res_product;
                rd_word[RES_READY_BIT] = res_ready;
            end
            default: begin
                rd_resp = RESP_ON_UNMAPPED;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= op_write ? OKAY : RESP_ON_UNMAPPED;
        end
        if (rd_hs) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    // ----------------------------------------
    // checks
    assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

    assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

    assert property (@(posedge clk) disable iff (rst)
        !(in_flight == '0 && mul.done && !op_write)
        && !(in_flight == CNT_MAX && op_write && !mul.done));

    // partial writes are not supported
    assert property (@(posedge clk) disable iff (rst)
        wr_hs |-> &wstrb);

endmodule

`default_nettype wire

// File: logic/cla_adder.sv
`timescale 1ns/10ps
`default_nettype none

module cla_adder #(
    parameter int WIDTH = mul_pkg::PRODUCT_W
) (
    input  logic clk,
    input  logic rst,
    mul_if.adder mul
);

    logic [WIDTH-1:0] x;
    logic [WIDTH-1:0] y;
    logic [WIDTH-1:0] g;
    logic [WIDTH-1:0] p;
    logic [WIDTH-1:0] carry;

    assign x = mul.sum_row;
    assign y = mul.carry_row;

    // generate and propagate per column
    assign g = x & y;
    assign p = x ^ y;

    // ----------------------------------------
    // look-ahead carries with no carry in
    // carry[i] = OR over j<i of g[j] & p[j+1] & ... & p[i-1]
    always_comb begin
        logic term;

        carry = '0;
        for (int i = 1; i < WIDTH; i++) begin
            for (int j = 0; j < i; j++) begin
                term = g[j];
                for (int k = j + 1; k < i; k++) begin
                    term = term & p[k];
                end
                carry[i] = carry[i] | term;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mul.done <= 1'b0;
        end else begin
            mul.done <= mul.rows_valid;
        end
    end

    // carry out of the top column is dropped since the product fits
    always_ff @(posedge clk) begin
        if (mul.rows_valid) begin
            mul.product <= p ^ carry;
        end
    end

    // done and the full sum arrive one cycle after the rows
    assert property (@(posedge clk) disable iff (rst)
        mul.rows_valid |=> mul.done && mul.product == $past(WIDTH'(x + y)));

endmodule

`default_nettype wire

// File: logic/wallace_reduce.sv
`timescale 1ns/10ps
`default_nettype none

module wallace_reduce (
    input  logic   clk,
    input  logic   rst,
    mul_if.reducer mul
);
    import mul_pkg::*;

    operand_t pp [OPERAND_W];

    // index n of a stage output stands for cell n of that stage
    logic [16:1] s1, c1;
    logic [16:1] s2, c2;
    logic [10:1] s3, c3;
    logic [11:1] s4, c4;

    product_t sum_d;
    product_t carry_d;

    // {carry, sum}
    function automatic logic [1:0] ha(input logic x, input logic y);
        return {x & y, x ^ y};
    endfunction

    function automatic logic [1:0] fa(input logic x, input logic y, input logic z);
        return {(x & y) | (x & z) | (y & z), x ^ y ^ z};
    endfunction

    // row i is a masked by b[i], and its bit j sits in column i+j
    always_comb begin
        for (int i = 0; i < OPERAND_W; i++) begin
            pp[i] = mul.a & {OPERAND_W{mul.b[i]}};
        end
    end

    // ----------------------------------------
    // stage 1 reduces rows 0-2 and rows 3-5
    always_comb begin
        {c1[1], s1[1]}   = ha(pp[0][1], pp[1][0]);
        {c1[2], s1[2]}   = fa(pp[0][2], pp[1][1], pp[2][0]);
        {c1[3], s1[3]}   = fa(pp[0][3], pp[1][2], pp[2][1]);
        {c1[4], s1[4]}   = fa(pp[0][4], pp[1][3], pp[2][2]);
        {c1[5], s1[5]}   = fa(pp[0][5], pp[1][4], pp[2][3]);
        {c1[6], s1[6]}   = fa(pp[0][6], pp[1][5], pp[2][4]);
        {c1[7], s1[7]}   = fa(pp[0][7], pp[1][6], pp[2][5]);
        {c1[8], s1[8]}   = ha(pp[1][7], pp[2][6]);
        {c1[9], s1[9]}   = ha(pp[3][1], pp[4][0]);
        {c1[10], s1[10]} = fa(pp[3][2], pp[4][1], pp[5][0]);
        {c1[11], s1[11]} = fa(pp[3][3], pp[4][2], pp[5][1]);
        {c1[12], s1[12]} = fa(pp[3][4], pp[4][3], pp[5][2]);
        {c1[13], s1[13]} = fa(pp[3][5], pp[4][4], pp[5][3]);
        {c1[14], s1[14]} = fa(pp[3][6], pp[4][5], pp[5][4]);
        {c1[15], s1[15]} = fa(pp[3][7], pp[4][6], pp[5][5]);
        {c1[16], s1[16]} = ha(pp[4][7], pp[5][6]);
    end

    // ----------------------------------------
    // stage 2 merges the two groups and takes in rows 6-7
    always_comb begin
        {c2[1], s2[1]}   = ha(s1[2], c1[1]);
        {c2[2], s2[2]}   = fa(s1[3], c1[2], pp[3][0]);
        {c2[3], s2[3]}   = fa(s1[4], c1[3], s1[9]);
        {c2[4], s2[4]}   = fa(s1[5], c1[4], s1[10]);
        {c2[5], s2[5]}   = fa(s1[6], c1[5], s1[11]);
        {c2[6], s2[6]}   = fa(s1[7], c1[6], s1[12]);
        {c2[7], s2[7]}   = fa(s1[8], c1[7], s1[13]);
        // column 9 takes the last bit of row 2 here
        {c2[8], s2[8]}   = fa(pp[2][7], c1[8], s1[14]);
        {c2[9], s2[9]}   = ha(c1[10], pp[6][0]);
        {c2[10], s2[10]} = fa(c1[11], pp[6][1], pp[7][0]);
        {c2[11], s2[11]} = fa(c1[12], pp[6][2], pp[7][1]);
        {c2[12], s2[12]} = fa(c1[13], pp[6][3], pp[7][2]);
        {c2[13], s2[13]} = fa(c1[14], pp[6][4], pp[7][3]);
        {c2[14], s2[14]} = fa(c1[15], pp[6][5], pp[7][4]);
        {c2[15], s2[15]} = fa(c1[16], pp[6][6], pp[7][5]);
        {c2[16], s2[16]} = ha(pp[6][7], pp[7][6]);
    end

    // ----------------------------------------
    // stage 3
    always_comb begin
        {c3[1], s3[1]}   = ha(s2[2], c2[1]);
        {c3[2], s3[2]}   = ha(s2[3], c2[2]);
        {c3[3], s3[3]}   = fa(s2[4], c2[3], c1[9]);
        {c3[4], s3[4]}   = fa(s2[5], c2[4], s2[9]);
        {c3[5], s3[5]}   = fa(s2[6], c2[5], s2[10]);
        {c3[6], s3[6]}   = fa(s2[7], c2[6], s2[11]);
        {c3[7], s3[7]}   = fa(s2[8], c2[7], s2[12]);
        {c3[8], s3[8]}   = fa(s1[15], c2[8], s2[13]);
        {c3[9], s3[9]}   = ha(s1[16], s2[14]);
        {c3[10], s3[10]} = ha(pp[5][7], s2[15]);
    end

    // ----------------------------------------
    // stage 4 and the two packed rows
    always_comb begin
        {c4[1], s4[1]}   = ha(s3[2], c3[1]);
        {c4[2], s4[2]}   = ha(s3[3], c3[2]);
        {c4[3], s4[3]}   = ha(s3[4], c3[3]);
        {c4[4], s4[4]}   = fa(s3[5], c3[4], c2[9]);
        {c4[5], s4[5]}   = fa(s3[6], c3[5], c2[10]);
        {c4[6], s4[6]}   = fa(s3[7], c3[6], c2[11]);
        {c4[7], s4[7]}   = fa(s3[8], c3[7], c2[12]);
        {c4[8], s4[8]}   = fa(s3[9], c3[8], c2[13]);
        {c4[9], s4[9]}   = fa(s3[10], c3[9], c2[14]);
        {c4[10], s4[10]} = fa(s2[16], c3[10], c2[15]);
        {c4[11], s4[11]} = ha(pp[7][7], c2[16]);

        // columns 0-4 are already final
        sum_d         = '0;
        sum_d[0]      = pp[0][0];
        sum_d[1]      = s1[1];
        sum_d[2]      = s2[1];
        sum_d[3]      = s3[1];
        sum_d[4]      = s4[1];
        sum_d[14:5]   = s4[11:2];
        carry_d       = '0;
        carry_d[15:5] = c4[11:1];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mul.rows_valid <= 1'b0;
        end else begin
            mul.rows_valid <= mul.start;
        end
    end

    always_ff @(posedge clk) begin
        if (mul.start) begin
            mul.sum_row   <= sum_d;
            mul.carry_row <= carry_d;
        end
    end

    // rows must add up to a*b of the operands seen with start
    assert property (@(posedge clk) disable iff (rst)
        mul.start |=> product_t'(mul.sum_row + mul.carry_row)
            == product_t'($past(mul.a)) * product_t'($past(mul.b)));

endmodule

`default_nettype wire

// File: logic/mul_if.sv
`timescale 1ns/10ps
`default_nettype none

interface mul_if;
    import mul_pkg::*;

    // operands, one start pulse per multiply
    logic     start;
    operand_t a;
    operand_t b;

    // two rows left after the tree
    logic     rows_valid;
    product_t sum_row;
    product_t carry_row;

    logic     done;
    product_t product;

    modport issuer (
        output start, a, b,
        input  done, product
    );

    modport reducer (
        input  start, a, b,
        output rows_valid, sum_row, carry_row
    );

    modport adder (
        input  rows_valid, sum_row, carry_row,
        output done, product
    );

endinterface

`default_nettype wire

// File: logic/mul_pkg.sv
`default_nettype none

package mul_pkg;

    // ----------------------------------------
    // datapath widths

    localparam int OPERAND_W = 8;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    typedef logic [OPERAND_W-1:0] operand_t;
    // also used for one reduced row of the tree
    typedef logic [PRODUCT_W-1:0] product_t;

    // operands to product, in clock edges
    localparam int PIPE_DEPTH = 2;

    // ----------------------------------------
    // register map

    localparam int AXIL_ADDR_W = 4;
    localparam int AXIL_DATA_W = 32;

    localparam logic [AXIL_ADDR_W-1:0] REG_OPERANDS = 4'h0;
    localparam logic [AXIL_ADDR_W-1:0] REG_RESULT   = 4'h4;

    // field positions inside the two registers
    localparam int OP_A_LSB      = 0;
    localparam int OP_B_LSB      = 8;
    localparam int RES_READY_BIT = 16;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

endpackage

`default_nettype wire
